//--- hdl/periph_pkg.sv
// ---------------------------------------------------------------------
// Peripheral input block shared definitions
// Widths, address map, debounce length and vector types
// ---------------------------------------------------------------------

package periph_pkg;

  // Input counts
  localparam int SW_W  = 16;
  localparam int BTN_W = 4;

  // Cycles a synchronised bit must hold before the output follows
  localparam int DEB_LEN   = 8;
  localparam int DEB_CNT_W = $clog2(DEB_LEN + 1);

  // Bus geometry
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int OFF_W  = 8;

  typedef logic [SW_W-1:0]         sw_vec_t;
  typedef logic [BTN_W-1:0]        btn_vec_t;
  typedef logic [ADDR_W-1:0]       bus_addr_t;
  typedef logic [DATA_W-1:0]       bus_data_t;
  typedef logic [OFF_W-1:0]        reg_off_t;
  typedef logic [ADDR_W-OFF_W-1:0] blk_sel_t;
  typedef logic [DEB_CNT_W-1:0]    deb_cnt_t;

  // Block select, address bits 11..8
  localparam blk_sel_t SEL_SW  = 'd0;
  localparam blk_sel_t SEL_BTN = 'd1;
  localparam blk_sel_t SEL_HUB = 'd15;

  // Register offsets in the low address byte
  localparam reg_off_t REG_VALUE = 8'h00;
  localparam reg_off_t REG_LIVE  = 8'h04;
  localparam reg_off_t REG_MASK  = 8'h04;
  localparam reg_off_t REG_CAUSE = 8'h00;

endpackage

//--- hdl/periph_bus_if.sv
// ---------------------------------------------------------------------
// Internal register bus between the hub and one controller
// Single-cycle request, one-cycle registered read data
// ---------------------------------------------------------------------

`timescale 1ns/1ps

interface periph_bus_if;

  // Request strobe, one cycle per access
  logic                 req;
  logic                 we;
  // Register offset inside the selected block
  periph_pkg::reg_off_t off;
  periph_pkg::bus_data_t wdata;
  // Registered read data, held until the next read
  periph_pkg::bus_data_t rdata;

  // Hub side
  modport host (
    output req,
    output we,
    output off,
    output wdata,
    input  rdata
  );

  // Controller side
  modport dev (
    input  req,
    input  we,
    input  off,
    input  wdata,
    output rdata
  );

endinterface

//--- hdl/input_debouncer.sv
// ---------------------------------------------------------------------
// Input debouncer
// Two-flop synchroniser and per-bit stability counter
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module input_debouncer #(
  parameter type vec_t = logic [0:0]
) (
  input  logic clk_i,
  input  logic rst_i,
  input  vec_t raw_i,
  output vec_t stable_o
);

  // First and second synchroniser stages
  vec_t meta_q;
  vec_t sync_q;

  // One stability counter per input bit
  periph_pkg::deb_cnt_t cnt_q [$bits(vec_t)];

  // ------------------------------------------------------------------
  // Synchroniser and debounce counters
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      meta_q   <= '0;
      sync_q   <= '0;
      stable_o <= '0;
      for (int i = 0; i < $bits(vec_t); i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      meta_q <= raw_i;
      sync_q <= meta_q;
      for (int i = 0; i < $bits(vec_t); i++) begin
        if (sync_q[i] == stable_o[i]) begin
          // Input agrees with output, nothing to count
          cnt_q[i] <= '0;
        end else if (cnt_q[i] == periph_pkg::deb_cnt_t'(periph_pkg::DEB_LEN)) begin
          // Held long enough, output follows
          cnt_q[i]    <= '0;
          stable_o[i] <= sync_q[i];
        end else begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // Output bit moves only after its counter ran the full length
  for (genvar i = 0; i < $bits(vec_t); i++) begin : g_chk
    a_deb_hold: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (!$past(rst_i) && $changed(stable_o[i]))
        |-> ($past(cnt_q[i]) == periph_pkg::DEB_LEN)
    );
  end

endmodule

//--- hdl/sw_ctrl.sv
// ---------------------------------------------------------------------
// Switch controller
// Debounced switches, snapshot register and change interrupt
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module sw_ctrl (
  input  logic                clk_i,
  input  logic                rst_i,
  input  periph_pkg::sw_vec_t sw_i,
  periph_bus_if.dev           bus,
  output logic                irq_o,
  input  logic                ret_i
);

  // Debounced value and its one-cycle delay
  periph_pkg::sw_vec_t sw_deb;
  periph_pkg::sw_vec_t sw_deb_q;

  // Value captured when the interrupt was raised
  periph_pkg::sw_vec_t snap_q;

  logic pend_q;
  logic sw_chg;

  input_debouncer #(
    .vec_t (periph_pkg::sw_vec_t)
  ) u_deb (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .raw_i    (sw_i),
    .stable_o (sw_deb)
  );

  // ------------------------------------------------------------------
  // Change detection and pending flag
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sw_deb_q <= '0;
    end else begin
      sw_deb_q <= sw_deb;
    end
  end

  // Any debounced bit moved this cycle
  assign sw_chg = (sw_deb != sw_deb_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
      snap_q <= '0;
    end else if (sw_chg && !pend_q) begin
      // Capture only when idle, snapshot holds until the return
      pend_q <= 1'b1;
      snap_q <= sw_deb;
    end else if (ret_i && pend_q) begin
      pend_q <= 1'b0;
    end
  end

  assign irq_o = pend_q;

  // ------------------------------------------------------------------
  // Register reads
  // ------------------------------------------------------------------

  // Writes have no target in this block
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus.rdata <= '0;
    end else if (bus.req && !bus.we) begin
      case (bus.off)
        periph_pkg::REG_VALUE: bus.rdata <= periph_pkg::bus_data_t'(snap_q);
        periph_pkg::REG_LIVE:  bus.rdata <= periph_pkg::bus_data_t'(sw_deb);
        default:               bus.rdata <= '0;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // Hub routes a return here only while pending, so a return
  // cycle never also sets the flag
  a_pend_no_set_on_ret: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(pend_q) |-> !$past(ret_i)
  );

endmodule

//--- hdl/btn_ctrl.sv
// ---------------------------------------------------------------------
// Button controller
// Press latch, per-button interrupt mask, write-one-to-clear
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module btn_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  periph_pkg::btn_vec_t btn_i,
  periph_bus_if.dev            bus,
  output logic                 irq_o,
  input  logic                 ret_i
);

  // Debounced buttons and the previous cycle
  periph_pkg::btn_vec_t btn_deb;
  periph_pkg::btn_vec_t btn_deb_q;
  periph_pkg::btn_vec_t btn_rise;

  periph_pkg::btn_vec_t latch_q;
  periph_pkg::btn_vec_t mask_q;

  logic clr_wr;
  logic mask_wr;

  input_debouncer #(
    .vec_t (periph_pkg::btn_vec_t)
  ) u_deb (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .raw_i    (btn_i),
    .stable_o (btn_deb)
  );

  // ------------------------------------------------------------------
  // Press detection and latch
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      btn_deb_q <= '0;
    end else begin
      btn_deb_q <= btn_deb;
    end
  end

  // Press is a debounced rising edge
  assign btn_rise = btn_deb & ~btn_deb_q;

  // Register write strobes
  assign clr_wr  = bus.req && bus.we && (bus.off == periph_pkg::REG_VALUE);
  assign mask_wr = bus.req && bus.we && (bus.off == periph_pkg::REG_MASK);

  // New presses always survive a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      latch_q <= '0;
    end else if (ret_i) begin
      latch_q <= btn_rise;
    end else if (clr_wr) begin
      latch_q <= (latch_q & ~bus.wdata[periph_pkg::BTN_W-1:0]) | btn_rise;
    end else begin
      latch_q <= latch_q | btn_rise;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q <= '0;
    end else if (mask_wr) begin
      mask_q <= bus.wdata[periph_pkg::BTN_W-1:0];
    end
  end

  // Interrupt while any enabled press is latched
  assign irq_o = |(latch_q & mask_q);

  // ------------------------------------------------------------------
  // Register reads
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus.rdata <= '0;
    end else if (bus.req && !bus.we) begin
      case (bus.off)
        periph_pkg::REG_VALUE: bus.rdata <= periph_pkg::bus_data_t'(latch_q);
        periph_pkg::REG_MASK:  bus.rdata <= periph_pkg::bus_data_t'(mask_q);
        default:               bus.rdata <= '0;
      endcase
    end
  end

endmodule

//--- hdl/periph_hub.sv
// ---------------------------------------------------------------------
// Peripheral hub
// Bus decode, read mux, interrupt combine, cause and return routing
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module periph_hub (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  bus_req_i,
  input  logic                  bus_we_i,
  input  periph_pkg::bus_addr_t bus_addr_i,
  input  periph_pkg::bus_data_t bus_wdata_i,
  output periph_pkg::bus_data_t bus_rdata_o,
  periph_bus_if.host            sw_bus,
  periph_bus_if.host            btn_bus,
  input  logic                  sw_irq_i,
  input  logic                  btn_irq_i,
  output logic                  sw_ret_o,
  output logic                  btn_ret_o,
  output logic                  irq_req_o,
  input  logic                  irq_ret_i
);

  periph_pkg::blk_sel_t  blk_sel;
  periph_pkg::blk_sel_t  blk_sel_q;
  periph_pkg::reg_off_t  reg_off;
  periph_pkg::bus_data_t cause_q;
  logic                  rd_en;

  // ------------------------------------------------------------------
  // Address decode and request fan-out
  // ------------------------------------------------------------------

  assign blk_sel = bus_addr_i[periph_pkg::ADDR_W-1:periph_pkg::OFF_W];
  assign reg_off = bus_addr_i[periph_pkg::OFF_W-1:0];
  assign rd_en   = bus_req_i && !bus_we_i;

  // Strobe only the selected controller
  assign sw_bus.req  = bus_req_i && (blk_sel == periph_pkg::SEL_SW);
  assign btn_bus.req = bus_req_i && (blk_sel == periph_pkg::SEL_BTN);

  assign sw_bus.we     = bus_we_i;
  assign sw_bus.off    = reg_off;
  assign sw_bus.wdata  = bus_wdata_i;
  assign btn_bus.we    = bus_we_i;
  assign btn_bus.off   = reg_off;
  assign btn_bus.wdata = bus_wdata_i;

  // ------------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------------

  // Select and cause sampled on reads only, so data holds
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      blk_sel_q <= periph_pkg::SEL_HUB;
      cause_q   <= '0;
    end else if (rd_en) begin
      blk_sel_q <= blk_sel;
      if (blk_sel == periph_pkg::SEL_HUB) begin
        if (reg_off == periph_pkg::REG_CAUSE) begin
          // Bit 0 switch, bit 1 button
          cause_q <= periph_pkg::bus_data_t'({btn_irq_i, sw_irq_i});
        end else begin
          cause_q <= '0;
        end
      end
    end
  end

  always_comb begin
    case (blk_sel_q)
      periph_pkg::SEL_SW:  bus_rdata_o = sw_bus.rdata;
      periph_pkg::SEL_BTN: bus_rdata_o = btn_bus.rdata;
      periph_pkg::SEL_HUB: bus_rdata_o = cause_q;
      default:             bus_rdata_o = '0;
    endcase
  end

  // ------------------------------------------------------------------
  // Interrupts
  // ------------------------------------------------------------------

  assign irq_req_o = sw_irq_i | btn_irq_i;

  // Return goes to the switch first
  assign sw_ret_o  = irq_ret_i & sw_irq_i;
  assign btn_ret_o = irq_ret_i & ~sw_irq_i;

  a_ret_onehot: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(sw_ret_o && btn_ret_o)
  );

  // Switch return takes effect in the controller on the next cycle
  a_sw_ret_clears: assert property (
    @(posedge clk_i) disable iff (rst_i)
    sw_ret_o |=> !sw_irq_i
  );

endmodule

//--- hdl/periph_top.sv
// ---------------------------------------------------------------------
// Input peripheral top level
// Hub plus switch and button controllers on plain ports
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module periph_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Processor bus
  input  logic                  bus_req_i,
  input  logic                  bus_we_i,
  input  periph_pkg::bus_addr_t bus_addr_i,
  input  periph_pkg::bus_data_t bus_wdata_i,
  output periph_pkg::bus_data_t bus_rdata_o,
  // Interrupt line
  output logic                  irq_req_o,
  input  logic                  irq_ret_i,
  // Raw inputs
  input  periph_pkg::sw_vec_t   sw_i,
  input  periph_pkg::btn_vec_t  btn_i
);

  // Per-source interrupt and return wires
  logic sw_irq;
  logic btn_irq;
  logic sw_ret;
  logic btn_ret;

  periph_bus_if sw_bus_if ();
  periph_bus_if btn_bus_if ();

  periph_hub u_hub (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rdata_o (bus_rdata_o),
    .sw_bus      (sw_bus_if.host),
    .btn_bus     (btn_bus_if.host),
    .sw_irq_i    (sw_irq),
    .btn_irq_i   (btn_irq),
    .sw_ret_o    (sw_ret),
    .btn_ret_o   (btn_ret),
    .irq_req_o   (irq_req_o),
    .irq_ret_i   (irq_ret_i)
  );

  sw_ctrl u_sw (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .sw_i  (sw_i),
    .bus   (sw_bus_if.dev),
    .irq_o (sw_irq),
    .ret_i (sw_ret)
  );

  btn_ctrl u_btn (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .btn_i (btn_i),
    .bus   (btn_bus_if.dev),
    .irq_o (btn_irq),
    .ret_i (btn_ret)
  );

endmodule

//--- sim/periph_tb.sv
// ---------------------------------------------------------------------
// Input peripheral testbench
// Directed tests for switches, buttons, interrupts and address map
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module periph_tb;

  // Debounce path plus change detect with margin
  localparam int SETTLE   = periph_pkg::DEB_LEN + 8;
  localparam int WAIT_MAX = 4 * periph_pkg::DEB_LEN + 20;

  logic                  clk;
  logic                  rst;
  logic                  bus_req;
  logic                  bus_we;
  periph_pkg::bus_addr_t bus_addr;
  periph_pkg::bus_data_t bus_wdata;
  periph_pkg::bus_data_t bus_rdata;
  logic                  irq_req;
  logic                  irq_ret;
  periph_pkg::sw_vec_t   sw;
  periph_pkg::btn_vec_t  btn;

  int          errors;
  logic [31:0] lcg_state;

  periph_top dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .bus_req_i   (bus_req),
    .bus_we_i    (bus_we),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_rdata_o (bus_rdata),
    .irq_req_o   (irq_req),
    .irq_ret_i   (irq_ret),
    .sw_i        (sw),
    .btn_i       (btn)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  // Block select in bits 11..8 and register offset in the low byte
  function automatic periph_pkg::bus_addr_t reg_addr(periph_pkg::blk_sel_t sel,
                                                     periph_pkg::reg_off_t off);
    return {sel, off};
  endfunction

  // LCG step whose upper half gives the switch pattern
  function automatic periph_pkg::sw_vec_t new_pattern(periph_pkg::sw_vec_t prev);
    periph_pkg::sw_vec_t p;
    p = prev;
    while (p == prev || p == '0) begin
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      p = lcg_state[31:16];
    end
    return p;
  endfunction

  task automatic check_eq(input string name, input periph_pkg::bus_data_t exp,
                          input periph_pkg::bus_data_t act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic bus_write(input periph_pkg::bus_addr_t addr,
                           input periph_pkg::bus_data_t data);
    @(negedge clk);
    bus_req   = 1'b1;
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(negedge clk);
    bus_req = 1'b0;
    bus_we  = 1'b0;
  endtask

  // Read data is valid one cycle after the request
  task automatic bus_read(input periph_pkg::bus_addr_t addr,
                          output periph_pkg::bus_data_t data);
    @(negedge clk);
    bus_req  = 1'b1;
    bus_we   = 1'b0;
    bus_addr = addr;
    @(negedge clk);
    bus_req = 1'b0;
    data    = bus_rdata;
  endtask

  task automatic read_check(input string name, input periph_pkg::bus_addr_t addr,
                            input periph_pkg::bus_data_t exp);
    periph_pkg::bus_data_t data;
    bus_read(addr, data);
    check_eq(name, exp, data);
  endtask

  task automatic wait_irq(input string name);
    int n;
    n = 0;
    while (irq_req !== 1'b1 && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (irq_req !== 1'b1) begin
      errors++;
      $display("%s: interrupt request never rose", name);
    end
  endtask

  task automatic pulse_ret();
    @(negedge clk);
    irq_ret = 1'b1;
    @(negedge clk);
    irq_ret = 1'b0;
  endtask

  task automatic settle();
    repeat (SETTLE) @(negedge clk);
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------

  task automatic test_reset();
    check_eq("reset irq", 0, irq_req);
    read_check("reset sw value", reg_addr(periph_pkg::SEL_SW, periph_pkg::REG_VALUE), 0);
    read_check("reset btn latch", reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_VALUE), 0);
    read_check("reset btn mask", reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_MASK), 0);
    read_check("reset cause", reg_addr(periph_pkg::SEL_HUB, periph_pkg::REG_CAUSE), 0);
  endtask

  task automatic test_switch();
    periph_pkg::sw_vec_t p1;
    periph_pkg::sw_vec_t p2;
    p1 = new_pattern(sw);
    @(negedge clk);
    sw = p1;
    wait_irq("switch first");
    read_check("switch cause", reg_addr(periph_pkg::SEL_HUB, periph_pkg::REG_CAUSE), 1);
    read_check("switch value", reg_addr(periph_pkg::SEL_SW, periph_pkg::REG_VALUE), p1);
    read_check("switch live", reg_addr(periph_pkg::SEL_SW, periph_pkg::REG_LIVE), p1);
    // A second change while pending leaves the snapshot alone
    p2 = new_pattern(p1);
    @(negedge clk);
    sw = p2;
    settle();
    read_check("switch held value", reg_addr(periph_pkg::SEL_SW, periph_pkg::REG_VALUE), p1);
    read_check("switch new live", reg_addr(periph_pkg::SEL_SW, periph_pkg::REG_LIVE), p2);
    pulse_ret();
    check_eq("switch irq after return", 0, irq_req);
    // Fresh change after the return raises a new interrupt
    p1 = new_pattern(p2);
    @(negedge clk);
    sw = p1;
    wait_irq("switch second");
    read_check("switch second value", reg_addr(periph_pkg::SEL_SW, periph_pkg::REG_VALUE), p1);
    pulse_ret();
    check_eq("switch second return", 0, irq_req);
  endtask

  task automatic test_glitch();
    logic seen;
    seen = 1'b0;
    @(negedge clk);
    sw[0] = ~sw[0];
    // Shorter than the debounce length
    repeat (periph_pkg::DEB_LEN / 2) @(negedge clk);
    sw[0] = ~sw[0];
    repeat (3 * periph_pkg::DEB_LEN) begin
      @(negedge clk);
      if (irq_req) seen = 1'b1;
    end
    check_eq("glitch irq", 0, seen);
    read_check("glitch live", reg_addr(periph_pkg::SEL_SW, periph_pkg::REG_LIVE), sw);
  endtask

  task automatic test_button();
    @(negedge clk);
    btn = 4'b0100;
    settle();
    check_eq("button masked irq", 0, irq_req);
    read_check("button latch", reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_VALUE), 4);
    @(negedge clk);
    btn = '0;
    settle();
    bus_write(reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_MASK), 4);
    wait_irq("button unmasked");
    read_check("button cause", reg_addr(periph_pkg::SEL_HUB, periph_pkg::REG_CAUSE), 2);
    // Write one to clear
    bus_write(reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_VALUE), 4);
    check_eq("button irq after clear", 0, irq_req);
    read_check("button cleared", reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_VALUE), 0);
  endtask

  task automatic test_priority();
    @(negedge clk);
    btn = 4'b0100;
    sw  = new_pattern(sw);
    wait_irq("priority");
    settle();
    read_check("priority both", reg_addr(periph_pkg::SEL_HUB, periph_pkg::REG_CAUSE), 3);
    // First return goes to the switch
    pulse_ret();
    read_check("priority button left", reg_addr(periph_pkg::SEL_HUB, periph_pkg::REG_CAUSE), 2);
    pulse_ret();
    read_check("priority none", reg_addr(periph_pkg::SEL_HUB, periph_pkg::REG_CAUSE), 0);
    check_eq("priority irq", 0, irq_req);
    @(negedge clk);
    btn = '0;
    settle();
  endtask

  task automatic test_unmapped();
    periph_pkg::blk_sel_t blk;
    blk = 5;
    // Latch button 1 outside the mask so a stray clear or mask write shows
    @(negedge clk);
    btn = 4'b0010;
    settle();
    @(negedge clk);
    btn = '0;
    settle();
    read_check("unmapped latch before", reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_VALUE), 2);
    // Leave nonzero read data first so the zero is a real result
    read_check("unmapped mask before", reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_MASK), 4);
    read_check("unmapped read", reg_addr(blk, 8'h00), 0);
    bus_write(reg_addr(blk, 8'h00), 32'hffff_ffff);
    bus_write(reg_addr(blk, 8'h04), 32'hffff_ffff);
    read_check("unmapped sw value", reg_addr(periph_pkg::SEL_SW, periph_pkg::REG_VALUE), sw);
    read_check("unmapped latch", reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_VALUE), 2);
    read_check("unmapped mask", reg_addr(periph_pkg::SEL_BTN, periph_pkg::REG_MASK), 4);
    read_check("unmapped cause", reg_addr(periph_pkg::SEL_HUB, periph_pkg::REG_CAUSE), 0);
    check_eq("unmapped irq", 0, irq_req);
  endtask

  // ------------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------------

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    irq_ret   = 1'b0;
    sw        = '0;
    btn       = '0;
    errors    = 0;
    lcg_state = 32'd11;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_switch();
    test_glitch();
    test_button();
    test_priority();
    test_unmapped();
    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/periph_pkg.sv
hdl/periph_bus_if.sv
hdl/input_debouncer.sv
hdl/sw_ctrl.sv
hdl/btn_ctrl.sv
hdl/periph_hub.sv
hdl/periph_top.sv
sim/periph_tb.sv

//--- Bender.yml
package:
  name: periph_input

dependencies: {}

sources:
  - hdl/periph_pkg.sv
  - hdl/periph_bus_if.sv
  - hdl/input_debouncer.sv
  - hdl/sw_ctrl.sv
  - hdl/btn_ctrl.sv
  - hdl/periph_hub.sv
  - hdl/periph_top.sv
  - target: simulation
    files:
      - sim/periph_tb.sv
